// ==== verilog/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  localparam int INSTR_W   = 32;
  localparam int OPCODE_HI = 31;
  localparam int OPCODE_LO = 21;
  localparam int OPCODE_W  = OPCODE_HI - OPCODE_LO + 1;
  localparam int RM_LSB    = 16;                        // Second source, bits 20:16
  localparam int RN_LSB    = 5;                         // First source, bits 9:5
  localparam int RD_LSB    = 0;                         // Destination, bits 4:0

  localparam logic [OPCODE_W-1:0] OP_ADD = 11'b10001011000;
  localparam logic [OPCODE_W-1:0] OP_SUB = 11'b11001011000;
  localparam logic [OPCODE_W-1:0] OP_AND = 11'b10001010000;
  localparam logic [OPCODE_W-1:0] OP_ORR = 11'b10101010000;

  localparam int ALU_W = 4;
  localparam logic [ALU_W-1:0] ALU_AND = 4'b0000;
  localparam logic [ALU_W-1:0] ALU_ORR = 4'b0001;
  localparam logic [ALU_W-1:0] ALU_ADD = 4'b0010;
  localparam logic [ALU_W-1:0] ALU_SUB = 4'b0110;

  localparam logic [4:0] ZERO_REG = 5'd31;              // Reads as zero, drops writes

  // Top bit flags a known R-format opcode, low bits give the ALU code
  function automatic logic [ALU_W:0] alu_decode(input logic [OPCODE_W-1:0] opcode);
    logic [ALU_W:0] result;
    case (opcode)
      OP_ADD:  result = {1'b1, ALU_ADD};
      OP_SUB:  result = {1'b1, ALU_SUB};
      OP_AND:  result = {1'b1, ALU_AND};
      OP_ORR:  result = {1'b1, ALU_ORR};
      default: result = '0;                             // No-op
    endcase
    return result;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/core_pkg.sv ====
`default_nettype none

package core_pkg;

  localparam int DATA_W     = 64;
  localparam int REG_IDX_W  = 5;
  localparam int LANES      = 2;                        // Instructions issued per cycle
  localparam int PROG_DEPTH = 64;                       // Program words
  localparam int PC_W       = 6;                        // Word index width

  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;

  // APB address map
  localparam logic [APB_ADDR_W-1:0] ADDR_PROG_BASE = 12'h000;  // One word per 4 bytes
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL      = 12'h100;
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS    = 12'h104;  // Bit 0 is busy
  localparam logic [APB_ADDR_W-1:0] ADDR_REG_BASE  = 12'h200;  // Low half, then high half

  localparam int CTRL_START_BIT = 31;                   // Length sits in bits 6:0

endpackage

`default_nettype wire

// ==== verilog/apb_host_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_host_port
  import core_pkg::*;
(
  input  logic                  CLOCK,
  input  logic                  reset,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [APB_DATA_W-1:0] pwdata,
  input  logic                  busy,
  input  logic [DATA_W-1:0]     read_data,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  prog_write,
  output logic [PC_W-1:0]       prog_index,
  output logic [APB_DATA_W-1:0] prog_word,
  output logic                  start,
  output logic [PC_W:0]         run_length,
  output logic [REG_IDX_W-1:0]  read_index
);

  logic                  setup;
  logic                  access;
  logic                  aligned;
  logic                  hit_prog;
  logic                  hit_ctrl;
  logic                  hit_status;
  logic                  hit_reg;
  logic                  refuse;
  logic [APB_ADDR_W-1:0] prog_offset;
  logic [APB_ADDR_W-1:0] reg_offset;
  logic [APB_DATA_W-1:0] rdata_next;

  assign setup  = psel && !penable;
  assign access = psel && penable;

  // Offsets wrap below the base, so one compare bounds each region
  assign aligned     = paddr[1:0] == 2'b00;
  assign prog_offset = paddr - ADDR_PROG_BASE;
  assign reg_offset  = paddr - ADDR_REG_BASE;
  assign hit_prog    = aligned && prog_offset < APB_ADDR_W'(4 * PROG_DEPTH);
  assign hit_reg     = aligned && reg_offset < APB_ADDR_W'(8 * (2 ** REG_IDX_W));
  assign hit_ctrl    = paddr == ADDR_CTRL;
  assign hit_status  = paddr == ADDR_STATUS;

  assign refuse = !(hit_prog || hit_ctrl || hit_status || hit_reg) ||
                  (pwrite && busy && (hit_prog || hit_ctrl));   // No reload mid-run

  assign prog_index = prog_offset[PC_W+1:2];
  assign read_index = reg_offset[REG_IDX_W+2:3];     // 8 bytes per register
  assign prog_word  = pwdata;
  assign run_length = pwdata[PC_W:0];

  // Writes land at the edge closing the access phase
  assign prog_write = access && pwrite && hit_prog && !pslverr;
  assign start      = access && pwrite && hit_ctrl && !pslverr && pwdata[CTRL_START_BIT];
  assign pready     = 1'b1;                          // Zero wait states

  always_comb begin
    rdata_next = '0;
    if (hit_status) begin
      rdata_next[0] = busy;
    end else if (hit_reg) begin
      rdata_next = reg_offset[2] ? read_data[DATA_W-1:APB_DATA_W]
                                 : read_data[APB_DATA_W-1:0];
    end
  end

  // Response is settled during setup and held through access
  always_ff @(posedge CLOCK) begin
    if (reset) begin
      pslverr <= 1'b0;
    end else if (setup) begin
      pslverr <= refuse;
    end else if (access) begin
      pslverr <= 1'b0;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (setup) begin
      prdata <= rdata_next;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pair_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_dispatch
  import core_pkg::*;
  import isa_pkg::*;
(
  input  logic               CLOCK,
  input  logic               reset,
  input  logic               prog_write,
  input  logic [PC_W-1:0]    prog_index,
  input  logic [INSTR_W-1:0] prog_word,
  input  logic               start,
  input  logic [PC_W:0]      run_length,
  output logic               busy,
  output logic               issue_valid [LANES],
  output logic [INSTR_W-1:0] issue_word [LANES]
);

  logic [INSTR_W-1:0] imem [PROG_DEPTH];
  logic [PC_W:0]      pc;                            // One bit wider than the index
  logic [PC_W:0]      length;
  logic               running;                       // Pairs still to issue
  logic [PC_W:0]      step;
  logic               open;
  logic               slot_valid [LANES];
  logic [INSTR_W-1:0] slot_word [LANES];

  // True when first writes a real register that second reads
  function automatic logic depends_on(input logic [INSTR_W-1:0] first,
                                      input logic [INSTR_W-1:0] second);
    logic [ALU_W:0]         decoded;
    logic [REG_IDX_W-1:0]   rd;
    decoded = alu_decode(first[OPCODE_HI:OPCODE_LO]);
    rd      = first[RD_LSB +: REG_IDX_W];
    return decoded[ALU_W] && rd != ZERO_REG &&
           (second[RN_LSB +: REG_IDX_W] == rd || second[RM_LSB +: REG_IDX_W] == rd);
  endfunction

  always_ff @(posedge CLOCK) begin
    if (prog_write) begin
      imem[prog_index] <= prog_word;
    end
  end

  // A slot closes past the length or on a dependency with an earlier slot
  always_comb begin
    open = running;
    step = '0;
    for (int k = 0; k < LANES; k++) begin
      slot_word[k] = imem[PC_W'(pc + k)];
      if ((pc + k) >= length) begin
        open = 1'b0;
      end
      for (int j = 0; j < k; j++) begin
        if (depends_on(slot_word[j], slot_word[k])) begin
          open = 1'b0;                               // Split the pair
        end
      end
      slot_valid[k] = open;
      if (open) begin
        step = step + 1'b1;
      end
    end
  end

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      busy    <= 1'b0;
      running <= 1'b0;
      pc      <= '0;
      length  <= '0;
      for (int k = 0; k < LANES; k++) begin
        issue_valid[k] <= 1'b0;
      end
    end else begin
      for (int k = 0; k < LANES; k++) begin
        issue_valid[k] <= slot_valid[k];
      end
      if (start) begin
        busy    <= 1'b1;
        running <= 1'b1;
        pc      <= '0;
        length  <= run_length;
      end else if (running) begin
        pc <= pc + step;
        if (step == '0) begin
          running <= 1'b0;                           // Slot 0 closed, program done
        end
      end else if (busy) begin
        busy <= 1'b0;                                // Last results written this edge
      end
    end
  end

  always_ff @(posedge CLOCK) begin
    for (int k = 0; k < LANES; k++) begin
      issue_word[k] <= slot_word[k];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exec_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_lane
  import core_pkg::*;
  import isa_pkg::*;
(
  input  logic                 CLOCK,
  input  logic                 reset,
  input  logic                 issue_valid,
  input  logic [INSTR_W-1:0]   issue_word,
  input  logic [DATA_W-1:0]    rn_data,
  input  logic [DATA_W-1:0]    rm_data,
  input  logic                 fwd_valid [LANES],
  input  logic [REG_IDX_W-1:0] fwd_rd [LANES],
  input  logic [DATA_W-1:0]    fwd_data [LANES],
  output logic [REG_IDX_W-1:0] rn_index,
  output logic [REG_IDX_W-1:0] rm_index,
  output logic                 result_valid,
  output logic [REG_IDX_W-1:0] result_rd,
  output logic [DATA_W-1:0]    result_data
);

  logic [OPCODE_W-1:0]  opcode;
  logic [ALU_W:0]       decoded;
  logic                 op_known;
  logic [ALU_W-1:0]     alu_code;
  logic [REG_IDX_W-1:0] rd;
  logic [DATA_W-1:0]    op_a;
  logic [DATA_W-1:0]    op_b;
  logic [DATA_W-1:0]    alu_out;

  assign opcode   = issue_word[OPCODE_HI:OPCODE_LO];
  assign decoded  = alu_decode(opcode);
  assign op_known = decoded[ALU_W];
  assign alu_code = decoded[ALU_W-1:0];

  assign rn_index = issue_word[RN_LSB +: REG_IDX_W];
  assign rm_index = issue_word[RM_LSB +: REG_IDX_W];
  assign rd       = issue_word[RD_LSB +: REG_IDX_W];

  // Later lanes override earlier ones, so lane 1 beats lane 0
  always_comb begin
    op_a = rn_data;
    op_b = rm_data;
    for (int i = 0; i < LANES; i++) begin
      if (fwd_valid[i] && fwd_rd[i] == rn_index) begin
        op_a = fwd_data[i];
      end
      if (fwd_valid[i] && fwd_rd[i] == rm_index) begin
        op_b = fwd_data[i];
      end
    end
  end

  always_comb begin
    case (alu_code)
      ALU_AND: alu_out = op_a & op_b;
      ALU_ORR: alu_out = op_a | op_b;
      ALU_ADD: alu_out = op_a + op_b;
      ALU_SUB: alu_out = op_a - op_b;
      default: alu_out = '0;
    endcase
  end

  // x31 never becomes a valid result, which keeps it out of forwarding
  always_ff @(posedge CLOCK) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= issue_valid && op_known && rd != ZERO_REG;
    end
  end

  always_ff @(posedge CLOCK) begin
    result_rd   <= rd;
    result_data <= alu_out;
  end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file
  import core_pkg::*;
(
  input  logic                 CLOCK,
  input  logic                 reset,
  input  logic [REG_IDX_W-1:0] rn_index [LANES],
  input  logic [REG_IDX_W-1:0] rm_index [LANES],
  input  logic                 wr_valid [LANES],
  input  logic [REG_IDX_W-1:0] wr_index [LANES],
  input  logic [DATA_W-1:0]    wr_data [LANES],
  input  logic [REG_IDX_W-1:0] read_index,
  output logic [DATA_W-1:0]    rn_data [LANES],
  output logic [DATA_W-1:0]    rm_data [LANES],
  output logic [DATA_W-1:0]    read_data
);

  logic [DATA_W-1:0] regs [2 ** REG_IDX_W];

  // Bypass pending writes, highest lane last; x31 is the all-ones index
  function automatic logic [DATA_W-1:0] read_port(input logic [REG_IDX_W-1:0] idx);
    logic [DATA_W-1:0] value;
    value = regs[idx];
    for (int i = 0; i < LANES; i++) begin
      if (wr_valid[i] && wr_index[i] == idx) begin
        value = wr_data[i];
      end
    end
    if (idx == {REG_IDX_W{1'b1}}) begin
      value = '0;
    end
    return value;
  endfunction

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      for (int n = 0; n < 2 ** REG_IDX_W; n++) begin
        regs[n] <= DATA_W'(n);                       // xN starts at N
      end
    end else begin
      for (int i = 0; i < LANES; i++) begin
        if (wr_valid[i] && wr_index[i] != {REG_IDX_W{1'b1}}) begin
          regs[wr_index[i]] <= wr_data[i];           // Lane 1 lands last
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      rn_data[i] = read_port(rn_index[i]);
      rm_data[i] = read_port(rm_index[i]);
    end
    read_data = read_port(read_index);
  end

endmodule

`default_nettype wire

// ==== verilog/dual_issue_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core
  import core_pkg::*;
  import isa_pkg::*;
(
  input  logic                  CLOCK,
  input  logic                  reset,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [APB_DATA_W-1:0] pwdata,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr
);

  logic                 prog_write;
  logic [PC_W-1:0]      prog_index;
  logic [INSTR_W-1:0]   prog_word;
  logic                 start;
  logic [PC_W:0]        run_length;
  logic                 busy;
  logic [REG_IDX_W-1:0] read_index;
  logic [DATA_W-1:0]    read_data;

  logic                 issue_valid [LANES];
  logic [INSTR_W-1:0]   issue_word [LANES];
  logic [REG_IDX_W-1:0] rn_index [LANES];
  logic [REG_IDX_W-1:0] rm_index [LANES];
  logic [DATA_W-1:0]    rn_data [LANES];
  logic [DATA_W-1:0]    rm_data [LANES];
  logic                 result_valid [LANES];
  logic [REG_IDX_W-1:0] result_rd [LANES];
  logic [DATA_W-1:0]    result_data [LANES];

  apb_host_port u_host (
    .CLOCK(CLOCK), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .busy(busy), .read_data(read_data),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .prog_write(prog_write), .prog_index(prog_index), .prog_word(prog_word),
    .start(start), .run_length(run_length), .read_index(read_index)
  );

  pair_dispatch u_dispatch (
    .CLOCK(CLOCK), .reset(reset),
    .prog_write(prog_write), .prog_index(prog_index), .prog_word(prog_word),
    .start(start), .run_length(run_length),
    .busy(busy), .issue_valid(issue_valid), .issue_word(issue_word)
  );

  // Every lane sees all result registers for forwarding
  for (genvar g = 0; g < LANES; g++) begin : g_lane
    exec_lane u_lane (
      .CLOCK(CLOCK), .reset(reset),
      .issue_valid(issue_valid[g]), .issue_word(issue_word[g]),
      .rn_data(rn_data[g]), .rm_data(rm_data[g]),
      .fwd_valid(result_valid), .fwd_rd(result_rd), .fwd_data(result_data),
      .rn_index(rn_index[g]), .rm_index(rm_index[g]),
      .result_valid(result_valid[g]), .result_rd(result_rd[g]),
      .result_data(result_data[g])
    );
  end

  register_file u_regfile (
    .CLOCK(CLOCK), .reset(reset),
    .rn_index(rn_index), .rm_index(rm_index),
    .wr_valid(result_valid), .wr_index(result_rd), .wr_data(result_data),
    .read_index(read_index),
    .rn_data(rn_data), .rm_data(rm_data), .read_data(read_data)
  );

endmodule

`default_nettype wire

// ==== test/dual_issue_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core_tb
  import core_pkg::*;
();

  localparam int MAX_RECORDS       = 256;
  localparam int CYCLES_PER_RECORD = 100;

  localparam logic [3:0] OP_END_FILE  = 4'h0;
  localparam logic [3:0] OP_WRITE     = 4'h1;
  localparam logic [3:0] OP_WRITE_ERR = 4'h2;
  localparam logic [3:0] OP_READ      = 4'h3;
  localparam logic [3:0] OP_WAIT_IDLE = 4'h4;
  localparam logic [3:0] OP_END_TEST  = 4'h5;

  logic                  CLOCK = 1'b0;
  logic                  reset;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  logic [47:0] records [MAX_RECORDS];                // Op, address, data
  int          record_count;
  logic        loaded = 1'b0;
  int          error_count;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;

  dual_issue_core uut (
    .CLOCK(CLOCK), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  always #4 CLOCK = ~CLOCK;                          // 8 ns period

  task automatic count_failure();
    error_count++;
    test_errors++;
  endtask

  // Starts and ends on a falling edge and spans one setup and one access cycle
  task automatic apb_transfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                              input logic [APB_DATA_W-1:0] wdata,
                              output logic [APB_DATA_W-1:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge CLOCK);
    penable = 1'b1;
    rdata   = prdata;                                // Registered at the setup edge
    err     = pslverr;
    if (pready !== 1'b1) begin
      $display("Error: pready at address 0x%h expected 0x1 got 0x%h", addr, pready);
      count_failure();
    end
    @(negedge CLOCK);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic run_record(input logic [47:0] rec);
    logic [3:0]            op;
    logic [APB_ADDR_W-1:0] addr;
    logic [APB_DATA_W-1:0] data;
    logic [APB_DATA_W-1:0] rdata;
    logic                  err;
    op   = rec[47:44];
    addr = rec[43:32];
    data = rec[31:0];
    case (op)
      OP_WRITE, OP_WRITE_ERR: begin
        apb_transfer(1'b1, addr, data, rdata, err);
        if (op == OP_WRITE && err !== 1'b0) begin
          $display("Write to address 0x%h was refused with a slave error", addr);
          count_failure();
        end
        if (op == OP_WRITE_ERR && err !== 1'b1) begin
          $display("Write to address 0x%h was accepted where a slave error was due", addr);
          count_failure();
        end
      end
      OP_READ: begin
        apb_transfer(1'b0, addr, '0, rdata, err);
        if (err !== 1'b0) begin
          $display("Read of address 0x%h returned a slave error", addr);
          count_failure();
        end
        if (rdata !== data) begin
          $display("Error: prdata at address 0x%h expected 0x%h got 0x%h", addr, data, rdata);
          count_failure();
        end
      end
      OP_WAIT_IDLE: begin
        rdata = 32'h1;
        while (rdata[0] !== 1'b0) begin              // Poll STATUS busy bit
          apb_transfer(1'b0, ADDR_STATUS, '0, rdata, err);
          if (err !== 1'b0) begin
            $display("Status read returned a slave error");
            count_failure();
          end
        end
      end
      OP_END_TEST: begin
        if (test_errors == 0) begin
          $display("Test %0d passed", data);
          tests_passed++;
        end else begin
          $display("Test %0d failed with %0d errors", data, test_errors);
          tests_failed++;
        end
        test_errors = 0;
      end
      default: begin
        $display("Pattern record holds unknown operation %0h", op);
        count_failure();
      end
    endcase
  endtask

  initial begin
    reset        = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    error_count  = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int i = 0; i < MAX_RECORDS; i++) begin
      records[i] = '0;                               // Op 0 ends the list
    end
    $readmemh("test/core_patterns.hex", records);
    record_count = 0;
    while (record_count < MAX_RECORDS && records[record_count][47:44] != OP_END_FILE) begin
      record_count++;
    end
    loaded = 1'b1;
    if (record_count == 0) begin
      $display("Pattern file holds no records");
      count_failure();
    end
    repeat (5) @(negedge CLOCK);
    reset = 1'b0;
    for (int i = 0; i < record_count; i++) begin
      run_record(records[i]);
    end
    $display("Tests passed %0d, tests failed %0d, failed checks %0d",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Budget scales with the length of the pattern list
  initial begin
    wait (loaded);
    repeat (record_count * CYCLES_PER_RECORD + 10) @(posedge CLOCK);
    $display("Timeout, the pattern list did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/core_patterns.hex ====
// Columns o_aaa_dddddddd: operation, APB address, data word
// Operations 1 write, 2 write refused, 3 read and compare, 4 wait idle, 5 end of test
// Test 1, reset state and address decode
3_104_00000000 3_200_00000000 3_238_00000007 3_23c_00000000
3_2f0_0000001e 3_2f4_00000000 3_2f8_00000000 3_2fc_00000000
2_108_00000000 2_300_00000000 5_000_00000001
// Test 2, independent pairs of ADD SUB AND ORR
1_000_8b02002a 1_004_cb0700ab 1_008_8a0e01ac 1_00c_aa08006f
1_100_80000004 4_000_00000000
3_250_00000003 3_258_fffffffe 3_25c_ffffffff 3_260_0000000c 3_278_0000000b
5_000_00000002
// Test 3, forwarding from both lanes with lane 1 winning on x16
1_000_8b020050 1_004_aa110230 1_008_8b100212 1_00c_cb140073
1_010_8b130255 1_014_8a170256 1_100_80000006 4_000_00000000
3_280_00000011 3_290_00000022 3_298_ffffffef 3_29c_ffffffff
3_2a8_00000011 3_2b0_00000002 5_000_00000003
// Test 4, split pair gives the sequential result
1_000_8b050098 1_004_cb060319 1_100_80000002 4_000_00000000
3_2c0_00000009 3_2c8_00000003 3_2cc_00000000 5_000_00000004
// Test 5, x31 write dropped, unknown opcode, odd length of 3
1_000_8b02003f 1_004_8b0903fa 1_008_1f00001b 1_00c_8b01003c
1_100_80000003 4_000_00000000
3_2f8_00000000 3_2d0_00000009 3_2d8_0000001b 3_2e0_0000001c
5_000_00000005
// Test 6, refused writes during a chain of eight dependent ADDs
1_000_8b1d03bd 1_004_8b1d03bd 1_008_8b1d03bd 1_00c_8b1d03bd
1_010_8b1d03bd 1_014_8b1d03bd 1_018_8b1d03bd 1_01c_8b1d03bd
1_100_80000008 2_01c_aa1f03fd 2_100_80000001 3_2a0_00000014 3_104_00000001
4_000_00000000 3_2e8_00001d00 3_2ec_00000000 5_000_00000006

// ==== dual_issue_core.f ====
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/apb_host_port.sv
verilog/pair_dispatch.sv
verilog/exec_lane.sv
verilog/register_file.sv
verilog/dual_issue_core.sv
test/dual_issue_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module dual_issue_core_tb \
  -f dual_issue_core.f -o dual_issue_core_sim
./obj_dir/dual_issue_core_sim | tee sim.log
if grep -q "ERRORS FOUND" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
